/* hdl/pool_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed sizes for the four-tile cluster
// Tile count and bank depth must be powers of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pool_pkg;

  // Cluster geometry
  localparam int unsigned NumTiles  = 4;
  localparam int unsigned BankWords = 256;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Word offset inside the byte address
  localparam int unsigned ByteOffset = 2;

  // Derived widths
  localparam int unsigned TileIdWidth = $clog2(NumTiles);
  localparam int unsigned RowWidth    = $clog2(BankWords);

  // Byte address issued by a master
  typedef logic [AddrWidth-1:0] addr_t;

  // One data word and its byte enables
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Bank select and initiator id share this width
  typedef logic [TileIdWidth-1:0] tile_id_t;

  // Word row inside one bank
  typedef logic [RowWidth-1:0] row_t;

endpackage : pool_pkg

/* hdl/spill_register.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-entry request buffer with valid/ready
// Full throughput when the consumer drains each cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spill_register import pool_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  row_t     row_i,
  input  tile_id_t ini_i,
  input  logic     wen_i,
  input  data_t    wdata_i,
  input  strb_t    be_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output row_t     row_o,
  output tile_id_t ini_o,
  output logic     wen_o,
  output data_t    wdata_o,
  output strb_t    be_o
);

  logic     full_q;
  logic     load;
  row_t     row_q;
  tile_id_t ini_q;
  logic     wen_q;
  data_t    wdata_q;
  strb_t    be_q;

  // Space is free when empty or when the entry leaves this cycle
  assign ready_o = !full_q || ready_i;
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (load) begin
      row_q   <= row_i;
      ini_q   <= ini_i;
      wen_q   <= wen_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  assign valid_o = full_q;
  assign row_o   = row_q;
  assign ini_o   = ini_q;
  assign wen_o   = wen_q;
  assign wdata_o = wdata_q;
  assign be_o    = be_q;

endmodule : spill_register

/* hdl/tcdm_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port word memory that never stalls
// Read data appears one cycle after acceptance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tcdm_bank import pool_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Request
  input  logic     req_valid_i,
  input  row_t     req_row_i,
  input  tile_id_t req_ini_i,
  input  logic     req_wen_i,
  input  data_t    req_wdata_i,
  input  strb_t    req_be_i,
  output logic     req_ready_o,
  // Response as a one-cycle strobe
  output logic     resp_valid_o,
  output tile_id_t resp_ini_o,
  output data_t    resp_rdata_o
);

  data_t    mem_q [BankWords];
  logic     rd_en;
  logic     wr_en;
  logic     resp_valid_q;
  tile_id_t resp_ini_q;
  data_t    resp_rdata_q;

  assign rd_en = req_valid_i && !req_wen_i;
  assign wr_en = req_valid_i && req_wen_i;

  // The bank accepts a request every cycle
  assign req_ready_o = 1'b1;

  // Byte-masked write
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_be_i[b]) begin
          mem_q[req_row_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word and initiator tag
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      resp_rdata_q <= mem_q[req_row_i];
      resp_ini_q   <= req_ini_i;
    end
  end

  // Writes stay silent
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= rd_en;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = resp_ini_q;
  assign resp_rdata_o = resp_rdata_q;

endmodule : tcdm_bank

/* hdl/pool_tile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile boundary with a spill stage ahead of the bank
// Adds one cycle to every bank access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pool_tile import pool_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Request from the crossbar
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  row_t     req_row_i,
  input  tile_id_t req_ini_i,
  input  logic     req_wen_i,
  input  data_t    req_wdata_i,
  input  strb_t    req_be_i,
  // Response to the crossbar
  output logic     resp_valid_o,
  output tile_id_t resp_ini_o,
  output data_t    resp_rdata_o
);

  // Registered request into the bank
  logic     spill_valid;
  logic     spill_ready;
  row_t     spill_row;
  tile_id_t spill_ini;
  logic     spill_wen;
  data_t    spill_wdata;
  strb_t    spill_be;

  spill_register i_spill (
    .clk_i  (clk_i      ),
    .rst_i  (rst_i      ),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .row_i  (req_row_i  ),
    .ini_i  (req_ini_i  ),
    .wen_i  (req_wen_i  ),
    .wdata_i(req_wdata_i),
    .be_i   (req_be_i   ),
    .valid_o(spill_valid),
    .ready_i(spill_ready),
    .row_o  (spill_row  ),
    .ini_o  (spill_ini  ),
    .wen_o  (spill_wen  ),
    .wdata_o(spill_wdata),
    .be_o   (spill_be   )
  );

  tcdm_bank i_bank (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_valid_i (spill_valid ),
    .req_row_i   (spill_row   ),
    .req_ini_i   (spill_ini   ),
    .req_wen_i   (spill_wen   ),
    .req_wdata_i (spill_wdata ),
    .req_be_i    (spill_be    ),
    .req_ready_o (spill_ready ),
    .resp_valid_o(resp_valid_o),
    .resp_ini_o  (resp_ini_o  ),
    .resp_rdata_o(resp_rdata_o)
  );

endmodule : pool_tile

/* hdl/tcdm_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Full crossbar over word-interleaved banks
// Masters must accept responses at all times
// Address bits above the bank space alias
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tcdm_xbar import pool_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Master requests
  input  logic     [NumTiles-1:0] mst_req_valid_i,
  input  addr_t    [NumTiles-1:0] mst_req_addr_i,
  input  logic     [NumTiles-1:0] mst_req_wen_i,
  input  data_t    [NumTiles-1:0] mst_req_wdata_i,
  input  strb_t    [NumTiles-1:0] mst_req_be_i,
  output logic     [NumTiles-1:0] mst_req_ready_o,
  // Master responses
  output logic     [NumTiles-1:0] mst_resp_valid_o,
  output data_t    [NumTiles-1:0] mst_resp_rdata_o,
  // Bank requests
  output logic     [NumTiles-1:0] bank_req_valid_o,
  input  logic     [NumTiles-1:0] bank_req_ready_i,
  output row_t     [NumTiles-1:0] bank_req_row_o,
  output tile_id_t [NumTiles-1:0] bank_req_ini_o,
  output logic     [NumTiles-1:0] bank_req_wen_o,
  output data_t    [NumTiles-1:0] bank_req_wdata_o,
  output strb_t    [NumTiles-1:0] bank_req_be_o,
  // Bank responses
  input  logic     [NumTiles-1:0] bank_resp_valid_i,
  input  tile_id_t [NumTiles-1:0] bank_resp_ini_i,
  input  data_t    [NumTiles-1:0] bank_resp_rdata_i
);

  tile_id_t [NumTiles-1:0] bank_sel;
  row_t     [NumTiles-1:0] row_sel;
  tile_id_t [NumTiles-1:0] rr_q;
  tile_id_t [NumTiles-1:0] gnt_idx;
  logic     [NumTiles-1:0] gnt_vld;

  // Bank from the low word bits and row from the bits above
  always_comb begin
    for (int m = 0; m < NumTiles; m++) begin
      bank_sel[m] = mst_req_addr_i[m][ByteOffset +: TileIdWidth];
      row_sel[m]  = mst_req_addr_i[m][ByteOffset+TileIdWidth +: RowWidth];
    end
  end

  // Round-robin pick per bank
  // Scanning from the far end lets the nearest requester win
  always_comb begin
    tile_id_t cand;
    for (int b = 0; b < NumTiles; b++) begin
      gnt_vld[b] = 1'b0;
      gnt_idx[b] = rr_q[b];
      for (int off = NumTiles - 1; off >= 0; off--) begin
        cand = tile_id_t'(rr_q[b] + off);
        if (mst_req_valid_i[cand] && bank_sel[cand] == tile_id_t'(b)) begin
          gnt_vld[b] = 1'b1;
          gnt_idx[b] = cand;
        end
      end
    end
  end

  // Pointer moves past the winner once the bank path takes it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumTiles; b++) begin
        if (bank_req_valid_o[b] && bank_req_ready_i[b]) begin
          rr_q[b] <= gnt_idx[b] + 1'b1;
        end
      end
    end
  end

  // Winner payload to each bank
  always_comb begin
    for (int b = 0; b < NumTiles; b++) begin
      bank_req_valid_o[b] = gnt_vld[b];
      bank_req_ini_o[b]   = gnt_idx[b];
      bank_req_row_o[b]   = row_sel[gnt_idx[b]];
      bank_req_wen_o[b]   = mst_req_wen_i[gnt_idx[b]];
      bank_req_wdata_o[b] = mst_req_wdata_i[gnt_idx[b]];
      bank_req_be_o[b]    = mst_req_be_i[gnt_idx[b]];
    end
  end

  // Idle masters see the ready of the bank they address
  always_comb begin
    for (int m = 0; m < NumTiles; m++) begin
      mst_req_ready_o[m] = bank_req_ready_i[bank_sel[m]] &&
                           (!mst_req_valid_i[m] || gnt_idx[bank_sel[m]] == tile_id_t'(m));
    end
  end

  // Route responses by initiator id
  always_comb begin
    for (int m = 0; m < NumTiles; m++) begin
      mst_resp_valid_o[m] = 1'b0;
      mst_resp_rdata_o[m] = '0;
      for (int b = 0; b < NumTiles; b++) begin
        if (bank_resp_valid_i[b] && bank_resp_ini_i[b] == tile_id_t'(m)) begin
          mst_resp_valid_o[m] = 1'b1;
          mst_resp_rdata_o[m] = bank_resp_rdata_i[b];
        end
      end
    end
  end

endmodule : tcdm_xbar

/* hdl/pool.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-tile shared memory of 4 KiB in total
// Read latency is two cycles after acceptance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pool import pool_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // One master port per tile
  input  logic  [NumTiles-1:0] req_valid_i,
  input  addr_t [NumTiles-1:0] req_addr_i,
  input  logic  [NumTiles-1:0] req_wen_i,
  input  data_t [NumTiles-1:0] req_wdata_i,
  input  strb_t [NumTiles-1:0] req_be_i,
  output logic  [NumTiles-1:0] req_ready_o,
  output logic  [NumTiles-1:0] resp_valid_o,
  output data_t [NumTiles-1:0] resp_rdata_o
);

  // Crossbar to bank paths
  logic     [NumTiles-1:0] bank_req_valid;
  logic     [NumTiles-1:0] bank_req_ready;
  row_t     [NumTiles-1:0] bank_req_row;
  tile_id_t [NumTiles-1:0] bank_req_ini;
  logic     [NumTiles-1:0] bank_req_wen;
  data_t    [NumTiles-1:0] bank_req_wdata;
  strb_t    [NumTiles-1:0] bank_req_be;
  logic     [NumTiles-1:0] bank_resp_valid;
  tile_id_t [NumTiles-1:0] bank_resp_ini;
  data_t    [NumTiles-1:0] bank_resp_rdata;

  tcdm_xbar i_xbar (
    .clk_i            (clk_i          ),
    .rst_i            (rst_i          ),
    .mst_req_valid_i  (req_valid_i    ),
    .mst_req_addr_i   (req_addr_i     ),
    .mst_req_wen_i    (req_wen_i      ),
    .mst_req_wdata_i  (req_wdata_i    ),
    .mst_req_be_i     (req_be_i       ),
    .mst_req_ready_o  (req_ready_o    ),
    .mst_resp_valid_o (resp_valid_o   ),
    .mst_resp_rdata_o (resp_rdata_o   ),
    .bank_req_valid_o (bank_req_valid ),
    .bank_req_ready_i (bank_req_ready ),
    .bank_req_row_o   (bank_req_row   ),
    .bank_req_ini_o   (bank_req_ini   ),
    .bank_req_wen_o   (bank_req_wen   ),
    .bank_req_wdata_o (bank_req_wdata ),
    .bank_req_be_o    (bank_req_be    ),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ini_i  (bank_resp_ini  ),
    .bank_resp_rdata_i(bank_resp_rdata)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    pool_tile i_tile (
      .clk_i       (clk_i             ),
      .rst_i       (rst_i             ),
      .req_valid_i (bank_req_valid[t] ),
      .req_ready_o (bank_req_ready[t] ),
      .req_row_i   (bank_req_row[t]   ),
      .req_ini_i   (bank_req_ini[t]   ),
      .req_wen_i   (bank_req_wen[t]   ),
      .req_wdata_i (bank_req_wdata[t] ),
      .req_be_i    (bank_req_be[t]    ),
      .resp_valid_o(bank_resp_valid[t]),
      .resp_ini_o  (bank_resp_ini[t]  ),
      .resp_rdata_o(bank_resp_rdata[t])
    );
  end : gen_tiles

endmodule : pool

/* tests/tb_pool_checks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Included inside tb_pool and uses its signals
// Model covers the 4 KiB space and aliases fold into it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_POOL_CHECKS_SVH
`define TB_POOL_CHECKS_SVH

  // Flat word model with one entry per bank word
  data_t model_mem   [NumTiles*BankWords];
  bit    model_known [NumTiles*BankWords];

  // Bank and row bits together form the word index
  function automatic int word_index(input addr_t addr);
    return int'(addr[ByteOffset +: TileIdWidth+RowWidth]);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    error_count++;
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%h got 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%h got 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_tile_id(input string name, input tile_id_t expected,
                               input tile_id_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%h got 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  // Returns once the request of master m is taken and drops valid on that edge
  task automatic wait_accept(input int m, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < Timeout) begin
      @(posedge clk_i);
      cycles++;
      if (req_ready[m]) begin
        ok = 1'b1;
      end
    end
    req_valid[m] <= 1'b0;
    if (!ok) begin
      report_error($sformatf("request of master %0d was never accepted", m));
    end
  endtask

  // Cycles from acceptance to the response strobe or -1 on timeout
  task automatic wait_response(input int m, output int latency);
    int cycles;
    latency = -1;
    cycles = 0;
    while (latency < 0 && cycles < Timeout) begin
      @(posedge clk_i);
      cycles++;
      if (resp_valid[m]) begin
        latency = cycles;
      end
    end
    if (latency < 0) begin
      report_error($sformatf("master %0d got no read response", m));
    end
  endtask

  // All response strobes stay low for the given number of edges
  task automatic expect_no_response(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      for (int m = 0; m < NumTiles; m++) begin
        check_valid($sformatf("resp_valid_o[%0d]", m), 1'b0, resp_valid[m]);
      end
    end
  endtask

`endif

/* tests/tb_pool.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the four-tile pool
// Only the conflict test overlaps masters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_pool import pool_pkg::*; ();

  localparam int Timeout = 100;
  localparam int Latency = 2;

  logic                  clk_i;
  logic                  rst_i;
  logic  [NumTiles-1:0] req_valid;
  addr_t [NumTiles-1:0] req_addr;
  logic  [NumTiles-1:0] req_wen;
  data_t [NumTiles-1:0] req_wdata;
  strb_t [NumTiles-1:0] req_be;
  logic  [NumTiles-1:0] req_ready;
  logic  [NumTiles-1:0] resp_valid;
  data_t [NumTiles-1:0] resp_rdata;
  int                    error_count;
  integer                seed;

  `include "tb_pool_checks.svh"

  pool UUT (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .req_valid_i (req_valid ),
    .req_addr_i  (req_addr  ),
    .req_wen_i   (req_wen   ),
    .req_wdata_i (req_wdata ),
    .req_be_i    (req_be    ),
    .req_ready_o (req_ready ),
    .resp_valid_o(resp_valid),
    .resp_rdata_o(resp_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  // One access from master m with the model updated on acceptance
  task automatic access(input int m, input addr_t addr, input logic wen,
                        input data_t wdata, input strb_t be);
    int    idx;
    int    lat;
    bit    ok;
    data_t expected;
    idx = word_index(addr);
    @(posedge clk_i);
    req_valid[m] <= 1'b1;
    req_addr[m]  <= addr;
    req_wen[m]   <= wen;
    req_wdata[m] <= wdata;
    req_be[m]    <= be;
    wait_accept(m, ok);
    if (ok && wen) begin
      model_mem[idx] = merge_bytes(model_mem[idx], wdata, be);
      model_known[idx] = model_known[idx] || (be == '1);
      // Writes never answer
      expect_no_response(Latency);
    end else if (ok) begin
      expected = model_mem[idx];
      wait_response(m, lat);
      if (lat >= 0) begin
        if (lat != Latency) begin
          report_error($sformatf("master %0d read took %0d cycles instead of %0d",
                                 m, lat, Latency));
        end
        check_data($sformatf("resp_rdata_o[%0d]", m), expected, resp_rdata[m]);
      end
    end
  endtask

  task automatic idle_after_reset();
    @(posedge clk_i);
    for (int m = 0; m < NumTiles; m++) begin
      check_valid($sformatf("resp_valid_o[%0d]", m), 1'b0, resp_valid[m]);
      check_valid($sformatf("req_ready_o[%0d]", m), 1'b1, req_ready[m]);
    end
  endtask

  task automatic local_write_read();
    // Bank 1 is local to master 1
    access(1, 32'h0000_0104, 1'b1, 32'hcafe_f00d, 4'hf);
    access(1, 32'h0000_0104, 1'b0, '0, '0);
  endtask

  task automatic byte_enable_merge();
    access(2, 32'h0000_0200, 1'b1, 32'h1122_3344, 4'hf);
    access(2, 32'h0000_0200, 1'b1, 32'haabb_ccdd, 4'b0101);
    access(3, 32'h0000_0200, 1'b0, '0, '0);
  endtask

  // Bank 1 with one row per master
  function automatic addr_t conflict_addr(input int m);
    return addr_t'(((48 + m) << 4) + 4);
  endfunction

  task automatic bank_conflict();
    int    next_grant;
    int    cyc;
    int    done_count;
    int    acc_cyc  [NumTiles];
    bit    pending  [NumTiles];
    data_t expected [NumTiles];
    for (int m = 0; m < NumTiles; m++) begin
      access(0, conflict_addr(m), 1'b1, $random(seed), 4'hf);
    end
    // Pointers go back to tile 0 while memory keeps its content
    apply_reset();
    @(posedge clk_i);
    for (int m = 0; m < NumTiles; m++) begin
      req_valid[m] <= 1'b1;
      req_addr[m]  <= conflict_addr(m);
      req_wen[m]   <= 1'b0;
      expected[m] = model_mem[word_index(conflict_addr(m))];
      pending[m]  = 1'b1;
      acc_cyc[m]  = 0;
    end
    next_grant = 0;
    cyc = 0;
    done_count = 0;
    while (done_count < NumTiles && cyc < Timeout) begin
      @(posedge clk_i);
      cyc++;
      for (int m = 0; m < NumTiles; m++) begin
        if (resp_valid[m]) begin
          if (pending[m] || cyc != acc_cyc[m] + Latency) begin
            report_error($sformatf("master %0d answered at the wrong cycle", m));
          end
          check_data($sformatf("resp_rdata_o[%0d]", m), expected[m], resp_rdata[m]);
          done_count++;
        end
        if (pending[m] && req_ready[m]) begin
          check_tile_id("req_ready_o grant", tile_id_t'(next_grant), tile_id_t'(m));
          next_grant++;
          pending[m] = 1'b0;
          acc_cyc[m] = cyc;
          req_valid[m] <= 1'b0;
        end
      end
    end
    if (done_count < NumTiles) begin
      report_error("conflicting reads did not all complete in time");
      req_valid <= '0;
    end
  endtask

  task automatic random_traffic();
    int     m;
    int     idx;
    integer rnd;
    logic   wen;
    addr_t  addr;
    data_t  wdata;
    strb_t  be;
    for (int n = 0; n < 200; n++) begin
      m = int'($unsigned($random(seed)) % NumTiles);
      // Upper bits stay random so high addresses alias
      addr = $random(seed);
      idx = int'($unsigned($random(seed)) % 32);
      addr[11:2] = idx[9:0];
      wdata = $random(seed);
      be = strb_t'($random(seed));
      rnd = $random(seed);
      wen = rnd[0];
      // Unknown words get a full write first
      if (!model_known[word_index(addr)]) begin
        wen = 1'b1;
        be = '1;
      end
      access(m, addr, wen, wdata, be);
    end
  endtask

  initial begin
    error_count = 0;
    seed = 24;
    rst_i     <= 1'b1;
    req_valid <= '0;
    req_addr  <= '0;
    req_wen   <= '0;
    req_wdata <= '0;
    req_be    <= '0;
    apply_reset();
    idle_after_reset();
    local_write_read();
    byte_enable_merge();
    bank_conflict();
    random_traffic();
    $display("Error count: %0d", error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_pool

/* pool.f */
+incdir+tests
hdl/pool_pkg.sv
hdl/spill_register.sv
hdl/tcdm_bank.sv
hdl/pool_tile.sv
hdl/tcdm_xbar.sv
hdl/pool.sv
tests/tb_pool.sv

/* run.sh */
#!/bin/sh
# Build and run the pool testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_pool -f pool.f

./obj_dir/Vtb_pool > sim.log 2>&1
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
